// ==== verilog/bridge_macros.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus widths, number of APB selects and the peripheral address map
// for the AHB-Lite to APB bridge.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

`define ADDR_W 32
`define DATA_W 32
`define NUM_SEL 3

// Three 64 MiB windows.
`define SLV0_BASE 32'h8000_0000
`define SLV1_BASE 32'h8400_0000
`define SLV2_BASE 32'h8800_0000
`define SLV_TOP 32'h8C00_0000

`endif

// ==== verilog/bridgePkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bridge types: AHB transfer type, AHB pipeline bundle and the
// registered APB request.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "bridge_macros.svh"

package bridgePkg;

	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// AHB side, registered and live values.
	typedef struct packed
	{
		logic [`ADDR_W-1:0]  addr1;
		logic [`ADDR_W-1:0]  addr2;
		logic [`DATA_W-1:0]  wdata1;
		logic [`DATA_W-1:0]  wdata2;
		logic                writeReg;
		logic                hwrite;   // Live address phase.
		logic [`ADDR_W-1:0]  haddr;    // Live address phase.
		logic [`NUM_SEL-1:0] sel;      // Decoded from haddr.
	} ahbPipe_t;

	typedef struct packed
	{
		logic [`NUM_SEL-1:0] sel;
		logic [`ADDR_W-1:0]  addr;
		logic [`DATA_W-1:0]  wdata;
		logic                write;
		logic                enable;
	} apbReq_t;

endpackage

// ==== verilog/ahbSlaveInterface.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB slave side: address and write data pipeline, transfer valid
// detection and peripheral select decode.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "bridge_macros.svh"

module ahbSlaveInterface
(
	input  logic                 Hclk,
	input  logic                 Hresetn,
	input  logic                 Hreadyin,
	input  logic                 Hwrite,
	input  bridgePkg::htrans_t   Htrans,
	input  logic [`ADDR_W-1:0]   Haddr,
	input  logic [`DATA_W-1:0]   Hwdata,
	output logic                 valid,
	output bridgePkg::ahbPipe_t  pipe
);

	logic [`ADDR_W-1:0]  addr1;
	logic [`ADDR_W-1:0]  addr2;
	logic [`DATA_W-1:0]  wdata1;
	logic [`DATA_W-1:0]  wdata2;
	logic                writeReg;
	logic [`NUM_SEL-1:0] sel;
	logic                active;

	// Two deep, so a held address phase can be paired with its data later.
	always_ff @(posedge Hclk)
	begin
		addr1  <= Haddr;
		addr2  <= addr1;
		wdata1 <= Hwdata;
		wdata2 <= wdata1;
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			writeReg <= 1'b0;
		else
			writeReg <= Hwrite;
	end

	// One window per peripheral.
	always_comb
	begin
		sel = '0;
		if (Haddr >= `SLV0_BASE && Haddr < `SLV1_BASE)
			sel[0] = 1'b1;
		else if (Haddr >= `SLV1_BASE && Haddr < `SLV2_BASE)
			sel[1] = 1'b1;
		else if (Haddr >= `SLV2_BASE && Haddr < `SLV_TOP)
			sel[2] = 1'b1;
	end

	// SEQ is handled like NONSEQ.
	assign active = (Htrans == bridgePkg::NONSEQ) || (Htrans == bridgePkg::SEQ);
	assign valid = Hreadyin && active && (|sel);

	always_comb
	begin
		pipe.addr1    = addr1;
		pipe.addr2    = addr2;
		pipe.wdata1   = wdata1;
		pipe.wdata2   = wdata2;
		pipe.writeReg = writeReg;
		pipe.hwrite   = Hwrite;
		pipe.haddr    = Haddr;
		pipe.sel      = sel;
	end

endmodule

// ==== verilog/apbFsmController.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB FSM controller: setup and enable phase sequencing, pipelined
// writes, registered APB request and Hreadyout, protocol checks.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "bridge_macros.svh"

module apbFsmController
(
	input  logic                 Hclk,
	input  logic                 Hresetn,
	input  logic                 valid,
	input  bridgePkg::ahbPipe_t  pipe,
	input  logic [`DATA_W-1:0]   Hwdata,
	output bridgePkg::apbReq_t   apb,
	output logic                 Hreadyout
);

	typedef enum logic [2:0]
	{
		Idle     = 3'b000,
		WWait    = 3'b001,
		Read     = 3'b010,
		Write    = 3'b011,
		WriteP   = 3'b100,
		REnable  = 3'b101,
		WEnable  = 3'b110,
		WEnableP = 3'b111
	} fsmState_t;

	fsmState_t state;
	fsmState_t stateNext;
	bridgePkg::apbReq_t apbNext;
	logic readyNext;
	logic [`NUM_SEL-1:0] selHold;

	// Select of the last accepted transfer.
	always_ff @(posedge Hclk)
	begin
		if (valid)
			selHold <= pipe.sel;
	end

	always_comb
	begin
		stateNext = state;
		apbNext   = apb;
		readyNext = Hreadyout;
		case (state)
			Idle, REnable, WEnable:
			begin
				apbNext.sel    = '0;
				apbNext.enable = 1'b0;
				readyNext      = 1'b1;
				if (valid && pipe.hwrite)
					stateNext = WWait;          // Wait for the data phase.
				else if (valid)
				begin
					stateNext     = Read;
					apbNext.sel   = pipe.sel;
					apbNext.addr  = pipe.haddr;
					apbNext.write = 1'b0;
					readyNext     = 1'b0;
				end
				else
					stateNext = Idle;
			end
			WWait:
			begin
				// Write data is live in this cycle.
				apbNext.sel    = selHold;
				apbNext.addr   = pipe.addr1;
				apbNext.wdata  = Hwdata;
				apbNext.write  = 1'b1;
				apbNext.enable = 1'b0;
				readyNext      = 1'b0;
				if (valid)
					stateNext = WriteP;
				else
					stateNext = Write;
			end
			Read:
			begin
				apbNext.enable = 1'b1;
				readyNext      = 1'b1;
				stateNext      = REnable;
			end
			Write:
			begin
				apbNext.enable = 1'b1;
				readyNext      = 1'b1;
				stateNext      = WEnable;
			end
			WriteP:
			begin
				apbNext.enable = 1'b1;
				// A pending read keeps the master stalled.
				readyNext      = pipe.writeReg;
				stateNext      = WEnableP;
			end
			WEnableP:
			begin
				apbNext.sel    = selHold;
				apbNext.addr   = pipe.addr2;
				apbNext.enable = 1'b0;
				readyNext      = 1'b0;
				if (!Hreadyout)
				begin
					// Pending transfer is a read.
					apbNext.write = 1'b0;
					stateNext     = Read;
				end
				else
				begin
					apbNext.write = 1'b1;
					apbNext.wdata = pipe.wdata1;
					if (valid)
						stateNext = WriteP;
					else
						stateNext = Write;
				end
			end
			default:
			begin
				apbNext.sel    = '0;
				apbNext.enable = 1'b0;
				stateNext      = Idle;
			end
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			state      <= Idle;
			apb.sel    <= '0;
			apb.write  <= 1'b0;
			apb.enable <= 1'b0;
			Hreadyout  <= 1'b0;
		end
		else
		begin
			state     <= stateNext;
			apb       <= apbNext;
			Hreadyout <= readyNext;
		end
	end

	// Enable comes right after a setup to the same peripheral and address.
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		apb.enable |-> $past(apb.sel != '0 && !apb.enable) &&
			$stable(apb.sel) && $stable(apb.addr));

	assert property (@(posedge Hclk) disable iff (!Hresetn) $onehot0(apb.sel));

	assert property (@(posedge Hclk) disable iff (!Hresetn) apb.enable |=> !apb.enable);

	// Pipelined write data lines up with the AHB data phase two cycles back.
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		state == WEnableP |-> apb.wdata == pipe.wdata2);

endmodule

// ==== verilog/ahbApbBridge.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-Lite to APB bridge top level.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "bridge_macros.svh"

module ahbApbBridge
(
	input  logic                Hclk,
	input  logic                Hresetn,
	input  logic                Hwrite,
	input  bridgePkg::htrans_t  Htrans,
	input  logic [`ADDR_W-1:0]  Haddr,
	input  logic [`DATA_W-1:0]  Hwdata,
	input  logic [`DATA_W-1:0]  Prdata,
	output logic                Hreadyout,
	output logic [`DATA_W-1:0]  Hrdata,
	output bridgePkg::apbReq_t  apb
);

	logic valid;
	bridgePkg::ahbPipe_t pipe;

	// Only slave on the bus, so its own ready is the bus ready.
	ahbSlaveInterface uSlave
	(
		.Hclk     (Hclk),
		.Hresetn  (Hresetn),
		.Hreadyin (Hreadyout),
		.Hwrite   (Hwrite),
		.Htrans   (Htrans),
		.Haddr    (Haddr),
		.Hwdata   (Hwdata),
		.valid    (valid),
		.pipe     (pipe)
	);

	apbFsmController uCtrl
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.valid     (valid),
		.pipe      (pipe),
		.Hwdata    (Hwdata),
		.apb       (apb),
		.Hreadyout (Hreadyout)
	);

	assign Hrdata = Prdata;

endmodule

// ==== testbench/tbClock.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock (period 20) and synchronous reset generator.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tbClock
(
	output logic Hclk,
	output logic Hresetn
);

	localparam int HalfPeriod = 10;
	localparam int ResetCycles = 3;

	initial
	begin
		Hclk = 1'b0;
		forever #HalfPeriod Hclk = ~Hclk;
	end

	initial
	begin
		Hresetn = 1'b0;
		repeat (ResetCycles) @(posedge Hclk);
		Hresetn <= 1'b1;
	end

endmodule

// ==== testbench/tbBridge.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bridge testbench: LCG stimulus, AHB master driver, APB peripheral
// memory, reference queue model, compare tasks and watchdog.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "bridge_macros.svh"

module tbBridge;

	localparam int NumXfers = 400;
	localparam int WatchdogTime = NumXfers * 4 * 20 + 200;
	localparam int TReset = 0;
	localparam int TOrder = 1;
	localparam int TWdata = 2;
	localparam int TRead = 3;
	localparam int TFilter = 4;
	localparam int TProtocol = 5;

	logic Hclk;
	logic Hresetn;
	logic Hwrite;
	bridgePkg::htrans_t Htrans;
	logic [`ADDR_W-1:0] Haddr;
	logic [`DATA_W-1:0] Hwdata;
	logic [`DATA_W-1:0] Prdata = '0;
	logic Hreadyout;
	logic [`DATA_W-1:0] Hrdata;
	bridgePkg::apbReq_t apb;

	logic [31:0] rngState = 32'h3ccb_d36c;
	logic [`DATA_W-1:0] periphMem [logic [`ADDR_W-1:0]];
	logic [`DATA_W-1:0] refMem [logic [`ADDR_W-1:0]];
	bridgePkg::apbReq_t expQ [$];
	bridgePkg::apbReq_t prevApb = '0;
	logic readySample = 1'b0;
	logic fillPending = 1'b0;
	int setupRun = 0;
	int acceptCount = 0;
	int enableCount = 0;
	int filteredCount = 0;
	string testName [6] = '{"reset", "order", "wdata", "read", "filter", "protocol"};
	int checkCount [6] = '{default: 0};
	int errCount [6] = '{default: 0};

	tbClock uClock
	(
		.Hclk    (Hclk),
		.Hresetn (Hresetn)
	);

	ahbApbBridge dut
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.Hwrite    (Hwrite),
		.Htrans    (Htrans),
		.Haddr     (Haddr),
		.Hwdata    (Hwdata),
		.Prdata    (Prdata),
		.Hreadyout (Hreadyout),
		.Hrdata    (Hrdata),
		.apb       (apb)
	);

	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Content of a word never written.
	function automatic logic [`DATA_W-1:0] fillWord(input logic [`ADDR_W-1:0] a);
		return {a[15:0], a[31:16]} ^ 32'h5ac3_96e1;
	endfunction

	function automatic logic [`NUM_SEL-1:0] windowSel(input logic [`ADDR_W-1:0] a);
		logic [`NUM_SEL-1:0] s;
		s = '0;
		if (a >= `SLV0_BASE && a < `SLV1_BASE)
			s[0] = 1'b1;
		else if (a >= `SLV1_BASE && a < `SLV2_BASE)
			s[1] = 1'b1;
		else if (a >= `SLV2_BASE && a < `SLV_TOP)
			s[2] = 1'b1;
		return s;
	endfunction

	task automatic makeTransfer(output bridgePkg::htrans_t t, output logic w,
		output logic [`ADDR_W-1:0] a, output logic [`DATA_W-1:0] d);
		logic [31:0] r;
		logic [`ADDR_W-1:0] base;
		rngState = lcgStep(rngState);
		r = rngState;
		case (r[31:28])
			4'd0, 4'd1: t = bridgePkg::IDLE;
			4'd2:       t = bridgePkg::BUSY;
			default:    t = bridgePkg::NONSEQ;
		endcase
		w = r[27];
		rngState = lcgStep(rngState);
		r = rngState;
		if (r[31:29] == 3'd0)
			a = r[28] ? (`SLV_TOP + {6'd0, r[25:2], 2'b00}) : {4'd0, r[27:2], 2'b00};
		else
		begin
			case (r[27:26])
				2'd0:    base = `SLV0_BASE;
				2'd1:    base = `SLV1_BASE;
				default: base = `SLV2_BASE;
			endcase
			a = base + {6'd0, r[25:24], 18'd0, r[19:16], 2'b00};  // Small pool so reads hit writes.
		end
		rngState = lcgStep(rngState);
		d = rngState;
		if (t == bridgePkg::IDLE || t == bridgePkg::BUSY || windowSel(a) == '0)
			filteredCount++;
	endtask

	task automatic reportFailure(input int id, input string msg);
		errCount[id]++;
		$display("%s: %s", testName[id], msg);
	endtask

	task automatic checkFlag(input int id, input logic want, input logic got);
		checkCount[id]++;
		if (got !== want)
		begin
			errCount[id]++;
			$display("error %s: expected %b actual %b", testName[id], want, got);
		end
	endtask

	task automatic checkData(input int id, input logic [`DATA_W-1:0] want,
		input logic [`DATA_W-1:0] got);
		checkCount[id]++;
		if (got !== want)
		begin
			errCount[id]++;
			$display("error %s: expected %h actual %h", testName[id], want, got);
		end
	endtask

	task automatic checkApb(input int id, input bridgePkg::apbReq_t want,
		input bridgePkg::apbReq_t got);
		bridgePkg::apbReq_t w;
		bridgePkg::apbReq_t g;
		w = want;
		g = got;
		w.wdata = '0;  // Write data has its own check.
		g.wdata = '0;
		checkCount[id]++;
		if (g !== w)
		begin
			errCount[id]++;
			$display("error %s: expected %h actual %h", testName[id], w, g);
		end
	endtask

	task automatic checkIdleOutputs();
		checkFlag(TReset, 1'b0, |apb.sel);
		checkFlag(TReset, 1'b0, apb.enable);
		checkFlag(TReset, 1'b0, apb.write);
	endtask

	task automatic reportTest(input int id);
		$display("%s: %0d checks, %0d errors", testName[id], checkCount[id], errCount[id]);
	endtask

	// AHB master. Address and data phases advance together on a ready cycle.
	task automatic driveTraffic();
		bridgePkg::htrans_t t;
		logic w;
		logic [`ADDR_W-1:0] a;
		logic [`DATA_W-1:0] d;
		logic [`DATA_W-1:0] pendData;
		int issued;
		logic done;
		makeTransfer(t, w, a, d);
		@(posedge Hclk);
		Htrans <= t;
		Hwrite <= w;
		Haddr <= a;
		pendData = d;
		issued = 1;
		done = 1'b0;
		while (!done)
		begin
			@(posedge Hclk);
			if (readySample)
			begin
				Hwdata <= pendData;
				if (issued < NumXfers)
				begin
					makeTransfer(t, w, a, d);
					Htrans <= t;
					Hwrite <= w;
					Haddr <= a;
					pendData = d;
					issued++;
				end
				else
				begin
					Htrans <= bridgePkg::IDLE;
					done = 1'b1;
				end
			end
		end
	endtask

	// APB peripherals. Read data is latched at the end of setup.
	always @(posedge Hclk)
	begin
		if (apb.sel != '0 && !apb.enable)
			Prdata <= periphMem.exists(apb.addr) ? periphMem[apb.addr] : fillWord(apb.addr);
		if (apb.enable && apb.write)
			periphMem[apb.addr] = apb.wdata;
	end

	// Monitor and reference model sampled mid cycle.
	always @(negedge Hclk)
	begin : monitor
		bridgePkg::apbReq_t want;
		logic [`DATA_W-1:0] rd;
		readySample = Hreadyout;
		if (Hresetn)
		begin
			if (apb.enable)
			begin
				if (setupRun != 1)
					reportFailure(TProtocol, $sformatf("enable after %0d setup cycles", setupRun));
				want = prevApb;
				want.enable = 1'b1;
				checkApb(TProtocol, want, apb);
				enableCount++;
				if (expQ.size() == 0)
					reportFailure(TFilter, "enable cycle with no accepted transfer");
				else
				begin
					want = expQ.pop_front();
					checkApb(TOrder, want, apb);
					if (want.write)
					begin
						checkData(TWdata, want.wdata, apb.wdata);
						refMem[want.addr] = want.wdata;
					end
					else
					begin
						rd = refMem.exists(want.addr) ? refMem[want.addr] : fillWord(want.addr);
						checkFlag(TRead, 1'b1, Hreadyout);
						checkData(TRead, rd, Hrdata);
					end
				end
			end
			else if (apb.sel != '0)
				checkFlag(TProtocol, 1'b0, Hreadyout);  // Setup stalls the master.
			setupRun = (apb.sel != '0 && !apb.enable) ? setupRun + 1 : 0;
			prevApb = apb;

			if (Hreadyout)
			begin
				// Data phase of the last accepted write ends now.
				if (fillPending)
				begin
					want = expQ.pop_back();
					want.wdata = Hwdata;
					expQ.push_back(want);
					fillPending = 1'b0;
				end
				if ((Htrans == bridgePkg::NONSEQ || Htrans == bridgePkg::SEQ) &&
					windowSel(Haddr) != '0)
				begin
					want.sel = windowSel(Haddr);
					want.addr = Haddr;
					want.wdata = '0;
					want.write = Hwrite;
					want.enable = 1'b1;
					expQ.push_back(want);
					fillPending = Hwrite;
					acceptCount++;
				end
			end
		end
	end

	initial
	begin : mainFlow
		int totalChecks;
		int totalErrors;
		Htrans = bridgePkg::IDLE;
		Hwrite = 1'b0;
		Haddr = '0;
		Hwdata = '0;

		@(negedge Hclk);
		while (!Hresetn)
		begin
			checkIdleOutputs();
			@(negedge Hclk);
		end
		checkIdleOutputs();  // First cycle out of reset.
		@(negedge Hclk);
		checkFlag(TReset, 1'b1, Hreadyout);
		reportTest(TReset);

		driveTraffic();
		while (expQ.size() != 0)
			@(negedge Hclk);
		repeat (4) @(negedge Hclk);  // Room for stray enables.

		checkCount[TFilter] += 1;
		if (enableCount != acceptCount)
			reportFailure(TFilter, $sformatf("%0d enable cycles for %0d accepted transfers",
				enableCount, acceptCount));

		reportTest(TOrder);
		reportTest(TWdata);
		reportTest(TRead);
		reportTest(TProtocol);
		reportTest(TFilter);
		totalChecks = 0;
		totalErrors = 0;
		for (int i = 0; i < 6; i++)
		begin
			totalChecks += checkCount[i];
			totalErrors += errCount[i];
		end
		$display("%0d checks, %0d errors, %0d transfers, %0d accepted, %0d filtered",
			totalChecks, totalErrors, NumXfers, acceptCount, filteredCount);
		if (totalErrors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial
	begin : watchdog
		#(WatchdogTime);
		$display("timeout: traffic did not drain within %0d time units", WatchdogTime);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/bridgePkg.sv
verilog/ahbSlaveInterface.sv
verilog/apbFsmController.sv
verilog/ahbApbBridge.sv
testbench/tbClock.sv
testbench/tbBridge.sv

// ==== Bender.yml ====
package:
  name: ahb_apb_bridge

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/bridgePkg.sv
      - verilog/ahbSlaveInterface.sv
      - verilog/apbFsmController.sv
      - verilog/ahbApbBridge.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tbClock.sv
      - testbench/tbBridge.sv
